/* tiny_cpu.f */
tiny_cpu_pkg.sv
instruction_mem.sv
control_unit.sv
alu.sv
register_file.sv
data_mem.sv
program_counter.sv
cpu.sv
tb_cpu.sv

/* Makefile */
TOP = tb_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -f tiny_cpu.f -Mdir obj_dir -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* tb_cpu.sv */
module tb_cpu import tiny_cpu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic    clk;
  logic    reset;
  logic    run;
  logic    load_req;
  load_t   load;
  logic    load_ack;
  logic    retire_valid;
  retire_t retire;
  logic    halted;

  logic [7:0]  img [256];  // Program image, loaded into the DUT
  int          img_len;
  logic [7:0]  m_regs [4];  // Reference model state
  logic [7:0]  m_dmem [256];
  bit          m_written [256];
  retire_t     exp_q [$];
  int          gap_q [$];
  retire_t     exp_rec;
  int          exp_gap;
  int          gap_now;
  int          cyc;
  logic [31:0] lcg_state = 32'd99;
  int          error_count;
  int          tests_run;
  int          tests_failed;
  int          elapsed;
  int          budget = 20;  // Cycles, grows with each program

  cpu DUT (
    .clk, .reset, .run, .load_req, .load, .load_ack,
    .retire_valid, .retire, .halted
  );

  always #50 clk = ~clk;

  function automatic logic [7:0] rand8();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic field_check(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic report_retire(input retire_t got, input retire_t exp);
    field_check("retire.pc", got.pc, exp.pc);
    field_check("retire.opcode", {4'h0, got.opcode}, {4'h0, exp.opcode});
    field_check("retire.reg_w_en", {7'h0, got.reg_w_en}, {7'h0, exp.reg_w_en});
    field_check("retire.reg_addr_w", {6'h0, got.reg_addr_w}, {6'h0, exp.reg_addr_w});
    field_check("retire.reg_data_w", got.reg_data_w, exp.reg_data_w);
    field_check("retire.mem_w_en", {7'h0, got.mem_w_en}, {7'h0, exp.mem_w_en});
    field_check("retire.mem_addr", got.mem_addr, exp.mem_addr);
    field_check("retire.mem_data", got.mem_data, exp.mem_data);
    field_check("retire.overflow", {7'h0, got.overflow}, {7'h0, exp.overflow});
  endtask

  task automatic emit(input opcode_t op, input logic [1:0] rd, input logic [1:0] rs);
    img[img_len[7:0]] = {op, rd, rs};
    img_len++;
  endtask

  task automatic emit_with_byte(input opcode_t op, input logic [1:0] rd, input logic [1:0] rs,
                                input logic [7:0] second);
    emit(op, rd, rs);
    img[img_len[7:0]] = second;
    img_len++;
  endtask

  task automatic start_program();
    img_len   = 0;
    m_regs    = '{default: 8'h00};
    m_written = '{default: 1'b0};
    exp_q.delete();
    gap_q.delete();
  endtask

  // One instruction of the ISA, pushes its retire record and cycle count
  task automatic execute_one(inout logic [7:0] pc, output bit done);
    retire_t          rec;
    logic [3:0]       opc;
    logic [1:0]       rd;
    logic [1:0]       rs;
    logic [1:0]       wa;
    logic [7:0]       a;
    logic [7:0]       b;
    logic [7:0]       imm;
    logic [7:0]       res;
    logic [7:0]       nxt;
    logic signed [8:0] s9;
    bit               wr;
    int               gap;
    {opc, rd, rs} = img[pc];
    a          = m_regs[rd];
    b          = m_regs[rs];
    imm        = img[pc + 8'd1];
    rec        = '0;
    rec.pc     = pc;
    rec.opcode = opcode_t'(opc);
    wr   = 1'b1;
    wa   = rd;
    res  = 8'h00;
    gap  = 2;
    nxt  = pc + 8'd1;
    done = 1'b0;
    case (opcode_t'(opc))
      op_add:
      begin
        s9           = $signed({a[7], a}) + $signed({b[7], b});
        res          = s9[7:0];
        rec.overflow = (s9[8] != s9[7]);  // Sign lost in 8 bits
      end
      op_sub:
      begin
        s9           = $signed({a[7], a}) - $signed({b[7], b});
        res          = s9[7:0];
        rec.overflow = (s9[8] != s9[7]);
      end
      op_and: res = a & b;
      op_or:  res = a | b;
      op_xor: res = a ^ b;
      op_shl: res = a << b[2:0];
      op_mov: res = b;
      op_li:
      begin
        res = imm;
        gap = 3;
        nxt = pc + 8'd2;
      end
      op_lw:
      begin
        res          = m_dmem[b];
        rec.mem_addr = b;
        gap          = 3;
      end
      op_sw:
      begin
        wr           = 1'b0;
        m_dmem[a]    = b;
        m_written[a] = 1'b1;
        rec.mem_w_en = 1'b1;
        rec.mem_addr = a;
        rec.mem_data = b;
      end
      op_beq, op_bne:
      begin
        wr  = 1'b0;
        gap = 3;
        nxt = ((a == b) == (opc == op_beq)) ? pc + 8'd2 + imm : pc + 8'd2;
      end
      op_j:
      begin
        wr  = 1'b0;
        gap = 3;
        nxt = imm;
      end
      op_jal:
      begin
        wa  = 2'd3;  // Link register
        res = pc + 8'd2;
        gap = 3;
        nxt = imm;
      end
      op_jr:
      begin
        wr  = 1'b0;
        nxt = b;
      end
      default:
      begin
        wr   = 1'b0;
        done = 1'b1;  // halt
      end
    endcase
    if (wr)
    begin
      rec.reg_w_en   = 1'b1;
      rec.reg_addr_w = wa;
      rec.reg_data_w = res;
      m_regs[wa]     = res;
    end
    exp_q.push_back(rec);
    gap_q.push_back(gap);
    pc = nxt;
  endtask

  task automatic reference_run();
    logic [7:0] pc;
    bit         done;
    int         steps;
    pc    = 8'h00;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 300)
    begin
      execute_one(pc, done);
      steps++;
    end
  endtask

  task automatic load_byte(input logic [7:0] addr, input logic [7:0] data);
    load.addr = addr;
    load.data = data;
    load_req  = 1'b1;
    do step(); while (!load_ack);
    load_req = 1'b0;
    do step(); while (load_ack);
  endtask

  task automatic run_test(input string name);
    int errs;
    errs   = error_count;
    budget = budget + img_len * 5 + 40;
    for (int a = 0; a < img_len; a++)
      load_byte(a[7:0], img[a[7:0]]);
    run = 1'b1;
    do step(); while (!halted);
    repeat (4) step();  // Window for a stray retire
    if (exp_q.size() != 0)
    begin
      error_count++;
      $display("%0d expected retire records never appeared in %s", exp_q.size(), name);
    end
    run   = 1'b0;
    reset = 1'b1;
    repeat (2) step();
    reset = 1'b0;
    step();
    tests_run++;
    if (error_count != errs)
    begin
      tests_failed++;
      $display("Test %s: failed", name);
    end
    else
      $display("Test %s: ok", name);
  endtask

  task automatic alu_program();
    start_program();
    repeat (3)
    begin
      emit_with_byte(op_li, 2'd0, 2'd0, rand8());
      emit_with_byte(op_li, 2'd1, 2'd0, rand8());
      for (int k = 0; k < 7; k++)
      begin
        emit(op_mov, 2'd2, 2'd0);
        emit(opcode_t'(k[3:0]), 2'd2, 2'd1);  // add through mov
      end
    end
    emit_with_byte(op_li, 2'd0, 2'd0, 8'h7F);  // Forced signed overflow
    emit_with_byte(op_li, 2'd1, 2'd0, 8'h01);
    emit(op_add, 2'd0, 2'd1);
    emit_with_byte(op_li, 2'd2, 2'd0, 8'h80);
    emit(op_sub, 2'd2, 2'd1);
    emit(op_halt, 2'd0, 2'd0);
    reference_run();
  endtask

  task automatic memory_program();
    logic [7:0] addrs [4];
    start_program();
    for (int k = 0; k < 4; k++)
    begin
      addrs[k] = rand8();
      emit_with_byte(op_li, 2'd0, 2'd0, addrs[k]);
      emit_with_byte(op_li, 2'd1, 2'd0, rand8());
      emit(op_sw, 2'd0, 2'd1);
    end
    for (int k = 3; k >= 0; k--)
    begin
      emit_with_byte(op_li, 2'd2, 2'd0, addrs[k]);
      emit(op_lw, 2'd3, 2'd2);
    end
    emit_with_byte(op_li, 2'd1, 2'd0, addrs[0]);
    emit(op_lw, 2'd1, 2'd1);  // Address register is also the target
    emit(op_halt, 2'd0, 2'd0);
    reference_run();
  endtask

  // Addresses in the comments are byte positions in the image
  task automatic branch_program();
    start_program();
    emit_with_byte(op_li, 2'd0, 2'd0, 8'h05);
    emit_with_byte(op_li, 2'd1, 2'd0, 8'h05);
    emit_with_byte(op_beq, 2'd0, 2'd1, 8'h02);  // 4, taken to 8
    emit_with_byte(op_li, 2'd2, 2'd0, 8'hEE);
    emit_with_byte(op_bne, 2'd0, 2'd1, 8'h02);  // 8, falls through
    emit_with_byte(op_li, 2'd1, 2'd0, 8'h07);
    emit_with_byte(op_beq, 2'd0, 2'd1, 8'h10);  // 12, falls through
    emit_with_byte(op_bne, 2'd0, 2'd1, 8'h02);  // 14, taken to 18
    emit(op_halt, 2'd0, 2'd0);
    emit(op_halt, 2'd0, 2'd0);
    emit_with_byte(op_j, 2'd0, 2'd0, 8'd22);  // 18
    emit(op_halt, 2'd0, 2'd0);
    emit(op_halt, 2'd0, 2'd0);
    emit_with_byte(op_jal, 2'd0, 2'd0, 8'd28);  // 22, r3 gets 24
    emit_with_byte(op_li, 2'd2, 2'd0, 8'h33);
    emit(op_halt, 2'd0, 2'd0);  // 26
    emit(op_halt, 2'd0, 2'd0);
    emit(op_jr, 2'd0, 2'd3);  // 28, back to 24
    reference_run();
  endtask

  task automatic timing_program();
    start_program();
    emit_with_byte(op_li, 2'd0, 2'd0, 8'h40);
    emit_with_byte(op_li, 2'd1, 2'd0, 8'h99);
    emit(op_sw, 2'd0, 2'd1);
    emit(op_lw, 2'd2, 2'd0);
    emit(op_xor, 2'd2, 2'd1);
    emit(op_mov, 2'd3, 2'd2);
    emit_with_byte(op_j, 2'd0, 2'd0, 8'(img_len + 2));
    emit(op_halt, 2'd0, 2'd0);
    reference_run();
  endtask

  // Built and executed together so lw only reads bytes already stored
  task automatic random_program(input int n);
    logic [7:0] pc;
    logic [7:0] r;
    logic [3:0] opc;
    bit         done;
    start_program();
    pc = 8'h00;
    for (int i = 0; i < n; i++)
    begin
      opc = 4'(rand8() % 8'd10);
      r   = rand8();
      if (opc == op_lw && !m_written[m_regs[r[3:2]]])
        opc = op_sw;
      if (opc == op_li)
        emit_with_byte(op_li, r[1:0], r[3:2], rand8());
      else
        emit(opcode_t'(opc), r[1:0], r[3:2]);
      execute_one(pc, done);
    end
    emit(op_halt, 2'd0, 2'd0);
    execute_one(pc, done);
  endtask

  // Cycle count per instruction and the next expected record
  always @(negedge clk)
  begin
    if (reset || !run)
      cyc = 0;
    else
      cyc = cyc + 1;
    if (retire_valid && !reset)
    begin
      gap_now = cyc;
      cyc     = 0;
      if (exp_q.size() == 0)
      begin
        error_count++;
        $display("Unexpected retire at %0t from pc %h", $time, retire.pc);
      end
      else
      begin
        exp_rec = exp_q.pop_front();
        exp_gap = gap_q.pop_front();
      end
    end
  end

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    $rose(load_req) |=> load_ack)
    else
    begin
      error_count++;
      $display("load_ack did not rise one cycle after load_req at %0t", $time);
    end

  release_one_cycle: assert property (@(posedge clk) disable iff (reset)
    $fell(load_req) |=> !load_ack)
    else
    begin
      error_count++;
      $display("load_ack did not fall one cycle after load_req at %0t", $time);
    end

  ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
    $fell(load_ack) |-> !$past(load_req))
    else
    begin
      error_count++;
      $display("load_ack fell while load_req was still high at %0t", $time);
    end

  retire_matches: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> retire == exp_rec)
    else
    begin
      error_count++;
      report_retire($sampled(retire), exp_rec);
    end

  retire_gap: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> gap_now == exp_gap)
    else
    begin
      error_count++;
      $display("Mismatch at %0t: retire gap got %0d expected %0d", $time, gap_now, exp_gap);
    end

  halted_holds: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else
    begin
      error_count++;
      $display("halted dropped without reset at %0t", $time);
    end

  halt_retires_first: assert property (@(posedge clk) disable iff (reset)
    $rose(halted) |-> $past(retire_valid) && $past(retire.opcode) == op_halt)
    else
    begin
      error_count++;
      $display("halted rose without a halt retiring at %0t", $time);
    end

  quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
    halted |-> !retire_valid)
    else
    begin
      error_count++;
      $display("An instruction retired after halt at %0t", $time);
    end

  initial
  begin : watchdog
    while (elapsed <= budget)
    begin
      @(posedge clk);
      elapsed++;
    end
    $display("Timeout after %0d cycles, the DUT did not reach halt", elapsed);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    clk      = 1'b0;
    reset    = 1'b1;
    run      = 1'b0;
    load_req = 1'b0;
    load     = '0;
    repeat (5) step();
    reset = 1'b0;
    alu_program();
    run_test("register ops");
    memory_program();
    run_test("memory");
    branch_program();
    run_test("control flow");
    timing_program();
    run_test("timing");
    random_program(40);
    run_test("random program");
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* cpu.sv */
module cpu import tiny_cpu_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    run,
  input  logic    load_req,
  input  load_t   load,
  output logic    load_ack,
  output logic    retire_valid,
  output retire_t retire,
  output logic    halted
);

  logic [data_w-1:0] pc;
  logic [data_w-1:0] instruction;
  logic [data_w-1:0] operand_byte;
  logic [data_w-1:0] operand;
  ctrl_t             ctrl;
  logic              pc_load;
  pc_sel_t           pc_sel;

  logic [data_w-1:0] reg_data_0;
  logic [data_w-1:0] reg_data_1;
  logic [data_w-1:0] reg_data_w;  // Write-back data
  logic [data_w-1:0] alu_result;
  logic              overflow;
  logic              equal;
  logic [data_w-1:0] mem_read_data;

  always_comb
  begin
    case (ctrl.wb_sel)
      wb_alu:     reg_data_w = alu_result;
      wb_operand: reg_data_w = operand;
      wb_mem:     reg_data_w = mem_read_data;
      default:    reg_data_w = pc + 8'd1;  // Return address, pc is on the operand byte
    endcase
  end

  instruction_mem u_imem (
    .clk, .reset, .run, .load_req, .load, .load_ack,
    .pc, .instruction, .operand_byte
  );

  control_unit u_ctrl (
    .clk, .reset, .run, .instruction, .operand_byte, .equal, .overflow, .pc,
    .reg_data_w, .mem_addr(reg_data_0), .mem_data(reg_data_1),
    .ctrl, .pc_load, .pc_sel, .operand, .retire_valid, .retire, .halted
  );

  alu u_alu (
    .alu_op(ctrl.alu_op), .in0(reg_data_0), .in1(reg_data_1),
    .out(alu_result), .overflow, .equal
  );

  register_file u_regs (
    .clk, .reset,
    .reg_addr_0(ctrl.reg_addr_0), .reg_addr_1(ctrl.reg_addr_1),
    .reg_addr_w(ctrl.reg_addr_w), .reg_w_en(ctrl.reg_w_en),
    .reg_data_w, .reg_data_0, .reg_data_1
  );

  data_mem u_dmem (
    .clk, .data_address(reg_data_0), .write_data(reg_data_1),
    .write_enable(ctrl.mem_w_en), .read_enable(ctrl.mem_r_en),
    .read_data(mem_read_data)
  );

  program_counter u_pc (
    .clk, .reset, .pc_load, .pc_sel,
    .jump_offset(operand), .reg_target(reg_data_1), .pc
  );

endmodule

/* program_counter.sv */
module program_counter import tiny_cpu_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              pc_load,
  input  pc_sel_t           pc_sel,
  input  logic [data_w-1:0] jump_offset,
  input  logic [data_w-1:0] reg_target,
  output logic [data_w-1:0] pc
);

  logic [data_w-1:0] pc_next;

  // Two-byte instructions step once past the opcode in operand state,
  // so pc already sits on the second byte when the target is chosen
  always_comb
  begin
    case (pc_sel)
      pc_seq:  pc_next = pc + 8'd1;
      pc_rel:  pc_next = pc + 8'd1 + jump_offset;  // Offset from the byte after the operand
      pc_abs:  pc_next = jump_offset;
      default: pc_next = reg_target;  // jr
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (pc_load)
      pc <= pc_next;
  end

endmodule

/* data_mem.sv */
module data_mem import tiny_cpu_pkg::*;
(
  input  logic              clk,
  input  logic [data_w-1:0] data_address,
  input  logic [data_w-1:0] write_data,
  input  logic              write_enable,
  input  logic              read_enable,
  output logic [data_w-1:0] read_data
);

  logic [data_w-1:0] bytes [mem_depth];

  always_ff @(posedge clk)
  begin
    if (write_enable)
      bytes[data_address] <= write_data;
  end

  // Read issued in exec, data ready for write-back in mem
  always_ff @(posedge clk)
  begin
    if (read_enable)
      read_data <= bytes[data_address];
  end

endmodule

/* register_file.sv */
module register_file import tiny_cpu_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [reg_addr_bits-1:0] reg_addr_0,
  input  logic [reg_addr_bits-1:0] reg_addr_1,
  input  logic [reg_addr_bits-1:0] reg_addr_w,
  input  logic                     reg_w_en,
  input  logic [data_w-1:0]        reg_data_w,
  output logic [data_w-1:0]        reg_data_0,
  output logic [data_w-1:0]        reg_data_1
);

  logic [data_w-1:0] regs [reg_count];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < reg_count; i++)
        regs[i] <= '0;
    end
    else if (reg_w_en)
      regs[reg_addr_w] <= reg_data_w;
  end

  // Combinational reads, no bypass of the pending write
  assign reg_data_0 = regs[reg_addr_0];
  assign reg_data_1 = regs[reg_addr_1];

endmodule

/* alu.sv */
module alu import tiny_cpu_pkg::*;
(
  input  opcode_t           alu_op,
  input  logic [data_w-1:0] in0,
  input  logic [data_w-1:0] in1,
  output logic [data_w-1:0] out,
  output logic              overflow,
  output logic              equal
);

  logic [data_w-1:0] sum;
  logic [data_w-1:0] diff;

  assign sum   = in0 + in1;
  assign diff  = in0 - in1;
  assign equal = (in0 == in1);  // Branch compare of rd and rs

  always_comb
  begin
    overflow = 1'b0;
    case (alu_op)
      op_add:
      begin
        out      = sum;
        overflow = (in0[data_w-1] == in1[data_w-1]) && (sum[data_w-1] != in0[data_w-1]);
      end
      op_sub:
      begin
        out      = diff;
        overflow = (in0[data_w-1] != in1[data_w-1]) && (diff[data_w-1] != in0[data_w-1]);
      end
      op_and: out = in0 & in1;
      op_or:  out = in0 | in1;
      op_xor: out = in0 ^ in1;
      op_shl: out = in0 << in1[2:0];  // Shift amount from low three bits
      op_mov: out = in1;
      default: out = '0;
    endcase
  end

endmodule

/* control_unit.sv */
module control_unit import tiny_cpu_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              run,
  input  logic [data_w-1:0] instruction,
  input  logic [data_w-1:0] operand_byte,
  input  logic              equal,
  input  logic              overflow,
  input  logic [data_w-1:0] pc,
  input  logic [data_w-1:0] reg_data_w,
  input  logic [data_w-1:0] mem_addr,
  input  logic [data_w-1:0] mem_data,
  output ctrl_t             ctrl,
  output logic              pc_load,
  output pc_sel_t           pc_sel,
  output logic [data_w-1:0] operand,
  output logic              retire_valid,
  output retire_t           retire,
  output logic              halted
);

  cpu_state_t               state;
  logic [data_w-1:0]        instr_q;
  logic [data_w-1:0]        pc_q;  // Address of the instruction in flight
  opcode_t                  op;
  opcode_t                  fetch_op;
  logic [reg_addr_bits-1:0] rd;
  logic [reg_addr_bits-1:0] rs;
  logic                     two_byte;
  logic                     branch_taken;

  assign op       = opcode_t'(instr_q[7:4]);
  assign rd       = instr_q[3:2];
  assign rs       = instr_q[1:0];
  assign fetch_op = opcode_t'(instruction[7:4]);
  assign two_byte = fetch_op inside {op_li, op_beq, op_bne, op_j, op_jal};

  assign branch_taken = (op == op_beq && equal) || (op == op_bne && !equal);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= fetch;
      instr_q <= '0;
      operand <= '0;
      halted  <= 1'b0;
    end
    else if (!run)
    begin
      state   <= fetch;
      operand <= '0;  // pc_abs below then parks the PC at 0
    end
    else
    begin
      case (state)
        fetch:
          if (!halted)
          begin
            instr_q <= instruction;
            pc_q    <= pc;
            state   <= two_byte ? tiny_cpu_pkg::operand : exec;
          end
        tiny_cpu_pkg::operand:
        begin
          operand <= operand_byte;
          state   <= exec;
        end
        exec:
        begin
          state <= (op == op_lw) ? mem : fetch;
          if (op == op_halt)
            halted <= 1'b1;
        end
        default:
          state <= fetch;  // mem ends the load
      endcase
    end
  end

  always_comb
  begin
    ctrl            = '0;
    ctrl.alu_op     = op;
    ctrl.reg_addr_0 = (op == op_lw) ? rs : rd;  // Read port 0 carries the memory address
    ctrl.reg_addr_1 = rs;
    ctrl.reg_addr_w = (op == op_jal) ? link_reg : rd;
    ctrl.wb_sel     = wb_alu;
    pc_load         = 1'b0;
    pc_sel          = pc_seq;
    retire_valid    = 1'b0;
    if (!run)
    begin
      pc_load = 1'b1;
      pc_sel  = pc_abs;
    end
    else
    begin
      case (state)
        tiny_cpu_pkg::operand:
          pc_load = 1'b1;  // Step past the opcode byte onto the operand
        exec:
        begin
          case (op)
            op_add, op_sub, op_and, op_or, op_xor, op_shl, op_mov:
              ctrl.reg_w_en = 1'b1;
            op_li:
            begin
              ctrl.reg_w_en = 1'b1;
              ctrl.wb_sel   = wb_operand;
            end
            op_lw:
              ctrl.mem_r_en = 1'b1;
            op_sw:
              ctrl.mem_w_en = 1'b1;
            op_beq, op_bne:
              if (branch_taken)
                pc_sel = pc_rel;
            op_j:
              pc_sel = pc_abs;
            op_jal:
            begin
              pc_sel        = pc_abs;
              ctrl.reg_w_en = 1'b1;
              ctrl.wb_sel   = wb_link;
            end
            op_jr:
              pc_sel = pc_reg;
            default: ;
          endcase
          pc_load      = (op != op_lw);
          retire_valid = (op != op_lw);
        end
        mem:
        begin
          ctrl.reg_w_en = 1'b1;
          ctrl.wb_sel   = wb_mem;
          pc_load       = 1'b1;
          retire_valid  = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Unused fields are zeroed so records compare cleanly
  always_comb
  begin
    retire.pc         = pc_q;
    retire.opcode     = op;
    retire.reg_w_en   = ctrl.reg_w_en;
    retire.reg_addr_w = ctrl.reg_w_en ? ctrl.reg_addr_w : '0;
    retire.reg_data_w = ctrl.reg_w_en ? reg_data_w : '0;
    retire.mem_w_en   = ctrl.mem_w_en;
    retire.mem_addr   = (op == op_lw || op == op_sw) ? mem_addr : '0;
    retire.mem_data   = ctrl.mem_w_en ? mem_data : '0;
    retire.overflow   = overflow;  // ALU gives 0 outside add and sub
  end

  // PC must sit on the second byte once the operand is taken
  pc_on_operand_byte: assert property (@(posedge clk) disable iff (reset)
    (run && state == tiny_cpu_pkg::operand) |=> pc == pc_q + 8'd1);

  halted_sticky: assert property (@(posedge clk)
    $fell(halted) |-> $past(reset));

endmodule

/* instruction_mem.sv */
module instruction_mem import tiny_cpu_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              run,
  input  logic              load_req,
  input  load_t             load,
  output logic              load_ack,
  input  logic [data_w-1:0] pc,
  output logic [data_w-1:0] instruction,
  output logic [data_w-1:0] operand_byte
);

  logic [data_w-1:0] prog [mem_depth];
  logic              load_write;

  // Byte is taken in the same edge that raises ack
  assign load_write = load_req && !load_ack && !run;

  // Four-phase handshake, ack follows req one cycle later
  always_ff @(posedge clk)
  begin
    if (reset)
      load_ack <= 1'b0;
    else if (load_write)
      load_ack <= 1'b1;
    else if (!load_req)
      load_ack <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load_write)
      prog[load.addr] <= load.data;
  end

  assign instruction  = prog[pc];
  assign operand_byte = prog[pc + 8'd1];  // Wraps at the top of memory

  ack_follows_req: assert property (@(posedge clk) disable iff (reset)
    $rose(load_ack) |-> $past(load_req));

  // Host must finish loading before the core runs
  no_load_while_run: assert property (@(posedge clk) disable iff (reset)
    run |-> !load_req);

endmodule

/* tiny_cpu_pkg.sv */
package tiny_cpu_pkg;

  localparam int data_w        = 8;    // Data and address width
  localparam int mem_depth     = 256;  // Bytes per memory
  localparam int reg_count     = 4;
  localparam int reg_addr_bits = $clog2(reg_count);

  localparam logic [reg_addr_bits-1:0] link_reg = 2'd3;  // jal return address

  // Write-back source select
  localparam logic [1:0] wb_alu     = 2'd0;
  localparam logic [1:0] wb_operand = 2'd1;
  localparam logic [1:0] wb_mem     = 2'd2;
  localparam logic [1:0] wb_link    = 2'd3;

  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_or   = 4'h3,
    op_xor  = 4'h4,
    op_shl  = 4'h5,
    op_mov  = 4'h6,
    op_li   = 4'h7,
    op_lw   = 4'h8,
    op_sw   = 4'h9,
    op_beq  = 4'hA,
    op_bne  = 4'hB,
    op_j    = 4'hC,
    op_jal  = 4'hD,
    op_jr   = 4'hE,
    op_halt = 4'hF
  } opcode_t;

  typedef enum logic [1:0] {
    fetch   = 2'd0,
    operand = 2'd1,
    exec    = 2'd2,
    mem     = 2'd3
  } cpu_state_t;

  // Next PC source
  typedef enum logic [1:0] {
    pc_seq = 2'd0,
    pc_rel = 2'd1,
    pc_abs = 2'd2,
    pc_reg = 2'd3
  } pc_sel_t;

  typedef struct packed {
    logic [data_w-1:0] addr;
    logic [data_w-1:0] data;
  } load_t;

  typedef struct packed {
    opcode_t                  alu_op;
    logic                     reg_w_en;
    logic [1:0]               wb_sel;
    logic                     mem_w_en;
    logic                     mem_r_en;
    logic [reg_addr_bits-1:0] reg_addr_w;
    logic [reg_addr_bits-1:0] reg_addr_0;
    logic [reg_addr_bits-1:0] reg_addr_1;
  } ctrl_t;

  typedef struct packed {
    logic [data_w-1:0]        pc;
    opcode_t                  opcode;
    logic                     reg_w_en;
    logic [reg_addr_bits-1:0] reg_addr_w;
    logic [data_w-1:0]        reg_data_w;
    logic                     mem_w_en;
    logic [data_w-1:0]        mem_addr;
    logic [data_w-1:0]        mem_data;
    logic                     overflow;
  } retire_t;

endpackage
